//--- source/fpa_pkg.sv
/* Single-precision adder types and constants */
`default_nettype none

package fpa_pkg;

    //////////////////////////////////////////////////
    // Field widths

    localparam int EXP_WIDTH  = 8;
    localparam int FRAC_WIDTH = 23;
    // Carry, lead, stored fraction and round bit
    localparam int FRAC_EX_WIDTH = FRAC_WIDTH + 3;

    // Bit positions inside the extended fraction
    localparam int ROUND_IDX = 0;
    localparam int LEAD_IDX  = FRAC_WIDTH + 1;
    localparam int CARRY_IDX = FRAC_WIDTH + 2;

    //////////////////////////////////////////////////
    // Limits

    // Reserved for infinity and NaN, never seen on the inputs
    localparam int EXP_MAX = (2 ** EXP_WIDTH) - 1;
    // Larger alignment distances shift everything out
    localparam int SHIFT_LIMIT = FRAC_WIDTH + 1;
    // Register stages from operands to result
    localparam int PIPE_DEPTH = 8;

    typedef logic [EXP_WIDTH-1:0]              exp_t;
    typedef logic [FRAC_WIDTH-1:0]             frac_t;
    typedef logic [FRAC_EX_WIDTH-1:0]          frac_ex_t;
    // Normalize shift distance, 0 up to LEAD_IDX
    typedef logic [$clog2(LEAD_IDX + 1)-1:0]   shift_t;

    // Regular form, 32 bits
    typedef struct packed {
        logic  sign;
        exp_t  exp;
        frac_t frac;
    } fp_word_t;

    // Total form, 35 bits
    typedef struct packed {
        logic  sign;
        exp_t  exp;
        logic  carry;
        logic  lead;
        frac_t frac;
        logic  round;
    } fp_total_t;

    // Greater and lesser magnitude operand
    typedef struct packed {
        fp_total_t big;
        fp_total_t little;
    } fpa_pair_t;

    // Carry, lead, fraction and round as one number
    function automatic frac_ex_t total_frac_ex(input fp_total_t t);
        return {t.carry, t.lead, t.frac, t.round};
    endfunction

    function automatic fp_total_t make_total(input logic sign, input exp_t exp,
                                             input frac_ex_t frac_ex);
        fp_total_t t;
        t.sign = sign;
        t.exp  = exp;
        {t.carry, t.lead, t.frac, t.round} = frac_ex;
        return t;
    endfunction

endpackage

`default_nettype wire

//--- source/fpa_align.sv
/* Operand alignment, stages 1 to 3 */
`default_nettype none

module fpa_align (
    input  wire                clk_i,
    input  wire                rst_i,
    input  wire fpa_pkg::fp_word_t fp_a_i,
    input  wire fpa_pkg::fp_word_t fp_b_i,
    input  wire                valid_i,
    output fpa_pkg::fpa_pair_t pair_o,
    output logic               valid_o
);
    import fpa_pkg::*;

    // Regular form to total form
    function automatic fp_total_t expand(input fp_word_t w);
        logic lead;
        exp_t exp;
        // Zero and subnormal: exponent 1, no hidden bit
        lead = (w.exp != '0);
        exp  = lead ? w.exp : exp_t'(1);
        return make_total(w.sign, exp, {1'b0, lead, w.frac, 1'b0});
    endfunction

    // One strobe bit per stage
    logic [2:0] valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[1:0], valid_i};
        end
    end

    assign valid_o = valid_q[2];

    //////////////////////////////////////////////////
    // Stage 1, select greater magnitude

    fp_word_t  s1_a_q;
    fp_word_t  s1_b_q;
    fp_total_t s1_a_tot;
    fp_total_t s1_b_tot;
    fp_total_t s1_big;
    fp_total_t s1_little;
    exp_t      s1_diff;

    always_ff @(posedge clk_i) begin
        s1_a_q <= fp_a_i;
        s1_b_q <= fp_b_i;
    end

    always_comb begin
        s1_a_tot = expand(s1_a_q);
        s1_b_tot = expand(s1_b_q);
        // Ties keep a as the big operand
        if (s1_a_tot.exp < s1_b_tot.exp) begin
            s1_big    = s1_b_tot;
            s1_little = s1_a_tot;
        end else begin
            s1_big    = s1_a_tot;
            s1_little = s1_b_tot;
        end
        s1_diff = s1_big.exp - s1_little.exp;
    end

    //////////////////////////////////////////////////
    // Stage 2, align the lesser operand

    fp_total_t s2_big_q;
    fp_total_t s2_little_q;
    exp_t      s2_diff_q;
    frac_ex_t  s2_frac_ex;
    fp_total_t s2_little;

    always_ff @(posedge clk_i) begin
        s2_big_q    <= s1_big;
        s2_little_q <= s1_little;
        s2_diff_q   <= s1_diff;
    end

    always_comb begin
        s2_frac_ex = total_frac_ex(s2_little_q);
        // Too far apart, nothing of it survives
        if (s2_diff_q > SHIFT_LIMIT) begin
            s2_frac_ex = '0;
        end else begin
            s2_frac_ex = s2_frac_ex >> s2_diff_q;
        end
        // Now on the scale of the big operand
        s2_little = make_total(s2_little_q.sign, s2_big_q.exp, s2_frac_ex);
    end

    //////////////////////////////////////////////////
    // Stage 3, round the shifted operand

    fp_total_t s3_big_q;
    fp_total_t s3_little_q;
    frac_ex_t  s3_frac_ex;
    fp_total_t s3_little;

    always_ff @(posedge clk_i) begin
        s3_big_q    <= s2_big_q;
        s3_little_q <= s2_little;
    end

    always_comb begin
        s3_frac_ex = total_frac_ex(s3_little_q);
        // Half up on the last bit shifted out
        // Lead is 0 after any shift, so no carry out here
        if (s3_frac_ex[ROUND_IDX]) begin
            s3_frac_ex = s3_frac_ex + 1'b1;
        end
        s3_little = make_total(s3_little_q.sign, s3_little_q.exp, s3_frac_ex);
    end

    assign pair_o = {s3_big_q, s3_little};

endmodule

`default_nettype wire

//--- source/fpa_signed_add.sv
/* Signed fraction addition, stages 4 to 6 */
`default_nettype none

module fpa_signed_add (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  wire fpa_pkg::fpa_pair_t pair_i,
    input  wire                 valid_i,
    output fpa_pkg::fp_total_t  sum_o,
    output logic                valid_o
);
    import fpa_pkg::*;

    logic [2:0] valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[1:0], valid_i};
        end
    end

    assign valid_o = valid_q[2];

    //////////////////////////////////////////////////
    // Stage 4, two's complement of the negative side

    fpa_pair_t s4_pair_q;
    frac_ex_t  s4_big_fx;
    frac_ex_t  s4_little_fx;

    always_ff @(posedge clk_i) begin
        s4_pair_q <= pair_i;
    end

    always_comb begin
        s4_big_fx    = total_frac_ex(s4_pair_q.big);
        s4_little_fx = total_frac_ex(s4_pair_q.little);
        // Like signs add as plain magnitudes
        if (s4_pair_q.big.sign != s4_pair_q.little.sign) begin
            if (s4_pair_q.big.sign) begin
                s4_big_fx = ~s4_big_fx + 1'b1;
            end else begin
                s4_little_fx = ~s4_little_fx + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stage 5, add

    frac_ex_t s5_big_fx_q;
    frac_ex_t s5_little_fx_q;
    exp_t     s5_exp_q;
    logic     s5_big_sign_q;
    logic     s5_little_sign_q;
    frac_ex_t s5_sum_fx;

    always_ff @(posedge clk_i) begin
        s5_big_fx_q      <= s4_big_fx;
        s5_little_fx_q   <= s4_little_fx;
        s5_exp_q         <= s4_pair_q.big.exp;
        s5_big_sign_q    <= s4_pair_q.big.sign;
        s5_little_sign_q <= s4_pair_q.little.sign;
    end

    // Wraps at the carry bit
    assign s5_sum_fx = s5_big_fx_q + s5_little_fx_q;

    //////////////////////////////////////////////////
    // Stage 6, back to sign and magnitude

    frac_ex_t s6_sum_fx_q;
    exp_t     s6_exp_q;
    logic     s6_big_sign_q;
    logic     s6_little_sign_q;
    frac_ex_t s6_fx;
    logic     s6_sign;

    always_ff @(posedge clk_i) begin
        s6_sum_fx_q      <= s5_sum_fx;
        s6_exp_q         <= s5_exp_q;
        s6_big_sign_q    <= s5_big_sign_q;
        s6_little_sign_q <= s5_little_sign_q;
    end

    always_comb begin
        s6_fx = s6_sum_fx_q;
        if (s6_big_sign_q != s6_little_sign_q) begin
            // Top bit acts as the sign of a difference
            if (s6_fx[CARRY_IDX]) begin
                s6_fx   = ~s6_fx + 1'b1;
                s6_sign = 1'b1;
            end else begin
                s6_sign = 1'b0;
            end
        end else begin
            s6_sign = s6_big_sign_q;
        end
    end

    assign sum_o = make_total(s6_sign, s6_exp_q, s6_fx);

endmodule

`default_nettype wire

//--- source/fpa_normalize.sv
/* Normalize and round, stages 7 and 8 */
`default_nettype none

module fpa_normalize (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  wire fpa_pkg::fp_total_t sum_i,
    input  wire                 valid_i,
    output fpa_pkg::fp_word_t   fp_o,
    output logic                valid_o
);
    import fpa_pkg::*;

    logic [1:0] valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[0], valid_i};
        end
    end

    assign valid_o = valid_q[1];

    //////////////////////////////////////////////////
    // Stage 7, leading one into the lead position

    fp_total_t s7_sum_q;
    frac_ex_t  s7_fx_in;
    frac_ex_t  s7_fx;
    exp_t      s7_exp;
    logic      s7_sign;
    shift_t    s7_dist;
    fp_total_t s7_norm;

    always_ff @(posedge clk_i) begin
        s7_sum_q <= sum_i;
    end

    always_comb begin
        s7_fx_in = total_frac_ex(s7_sum_q);
        s7_fx    = s7_fx_in;
        s7_exp   = s7_sum_q.exp;
        s7_sign  = s7_sum_q.sign;
        // Highest set bit wins, lead itself gives 0
        s7_dist = '0;
        for (int i = 0; i <= LEAD_IDX; i++) begin
            if (s7_fx_in[i]) begin
                s7_dist = shift_t'(LEAD_IDX - i);
            end
        end
        if (s7_fx_in == '0) begin
            // Exact zero is always +0
            s7_exp  = '0;
            s7_sign = 1'b0;
        end else if (s7_fx_in[CARRY_IDX]) begin
            s7_fx  = s7_fx_in >> 1;
            s7_exp = s7_sum_q.exp + 1'b1;
        end else if (s7_sum_q.exp > s7_dist) begin
            s7_fx  = s7_fx_in << s7_dist;
            s7_exp = s7_sum_q.exp - s7_dist;
        end else begin
            // Below normal range, flush but keep the sign
            s7_fx  = '0;
            s7_exp = '0;
        end
        s7_norm = make_total(s7_sign, s7_exp, s7_fx);
    end

    //////////////////////////////////////////////////
    // Stage 8, final round and pack

    fp_total_t s8_norm_q;
    frac_ex_t  s8_fx;
    exp_t      s8_exp;

    always_ff @(posedge clk_i) begin
        s8_norm_q <= s7_norm;
    end

    always_comb begin
        s8_fx  = total_frac_ex(s8_norm_q);
        s8_exp = s8_norm_q.exp;
        // Half up, no sticky bit
        if (s8_fx[ROUND_IDX]) begin
            s8_fx = s8_fx + 1'b1;
        end
        // All ones rolled over into the carry
        if (s8_fx[CARRY_IDX]) begin
            s8_fx  = s8_fx >> 1;
            s8_exp = s8_exp + 1'b1;
        end
    end

    // Hidden bit and round bit dropped
    assign fp_o = {s8_norm_q.sign, s8_exp, s8_fx[FRAC_WIDTH:1]};

endmodule

`default_nettype wire

//--- source/fp_adder.sv
/* Pipelined single-precision adder */
`default_nettype none

// PIPE_DEPTH register stages in total
// Align 3, signed add 3, normalize 2
// One pair per cycle, results in input order
module fp_adder (
    input  wire                clk_i,
    input  wire                rst_i,
    input  wire fpa_pkg::fp_word_t fp_a_i,
    input  wire fpa_pkg::fp_word_t fp_b_i,
    input  wire                valid_i,
    output fpa_pkg::fp_word_t  fp_o,
    output logic               valid_o
);
    import fpa_pkg::*;

    // Aligned pair, after stage 3
    fpa_pair_t align_pair;
    logic      align_valid;

    // Signed sum, after stage 6
    fp_total_t add_sum;
    logic      add_valid;

    //////////////////////////////////////////////////
    // Stages 1 to 3
    fpa_align i_fpa_align (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .fp_a_i  (fp_a_i),
        .fp_b_i  (fp_b_i),
        .valid_i (valid_i),
        .pair_o  (align_pair),
        .valid_o (align_valid)
    );

    // Stages 4 to 6
    fpa_signed_add i_fpa_signed_add (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .pair_i  (align_pair),
        .valid_i (align_valid),
        .sum_o   (add_sum),
        .valid_o (add_valid)
    );

    // Stages 7 and 8
    fpa_normalize i_fpa_normalize (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .sum_i   (add_sum),
        .valid_i (add_valid),
        .fp_o    (fp_o),
        .valid_o (valid_o)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
/* Testbench clock */
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    // Period of 10, low for the first half
    localparam int HALF_PERIOD = 5;

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(HALF_PERIOD);
        clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

//--- tb/fp_adder_properties.sv
/* Adder strobe assertions */
`default_nettype none

module fp_adder_properties (
    input wire                    clk_i,
    input wire                    rst_i,
    input wire                    valid_i,
    input wire                    valid_o,
    input wire fpa_pkg::fp_word_t fp_o
);
    import fpa_pkg::*;

    // Assertion failures so far
    int fail_count = 0;

    // Clean cycles since reset, saturates at PIPE_DEPTH
    logic [3:0] settle_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            settle_q <= '0;
        end else if (settle_q != PIPE_DEPTH) begin
            settle_q <= settle_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Strobe timing

    // First reset edge clears the valid registers
    reset_quiet: assert property (@(posedge clk_i) (rst_i && $past(rst_i)) |-> !valid_o)
        else begin
            $error("valid_o high while reset is held");
            fail_count++;
        end

    // Whole pipe filled since reset
    strobe_delay: assert property (@(posedge clk_i) disable iff (rst_i)
        (settle_q == PIPE_DEPTH) |-> (valid_o == $past(valid_i, PIPE_DEPTH)))
        else begin
            $error("valid_o does not follow valid_i by the pipeline depth");
            fail_count++;
        end

    result_known: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_o |-> !$isunknown(fp_o))
        else begin
            $error("fp_o has unknown bits while valid_o is high");
            fail_count++;
        end

endmodule

bind fp_adder fp_adder_properties i_fp_adder_properties (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .valid_o (valid_o),
    .fp_o    (fp_o)
);

`default_nettype wire

//--- tb/fp_adder_tb.sv
/* Adder testbench */
`default_nettype none

module fp_adder_tb;
    import fpa_pkg::*;

    localparam int RESET_CYCLES = 4;
    localparam int STREAM_LEN   = 64;
    localparam int NUM_TESTS    = 6;
    // Each test budgeted as long as the stream
    localparam int WATCHDOG_TIME = NUM_TESTS * (STREAM_LEN + PIPE_DEPTH + 10) * 10;

    logic     clk;
    logic     rst;
    fp_word_t fp_a;
    fp_word_t fp_b;
    logic     valid_in;
    fp_word_t fp_out;
    logic     valid_out;

    int tests_run    = 0;
    int tests_failed = 0;
    int check_count  = 0;
    int error_count  = 0;
    int errors_at_start;

    tb_clock_gen i_tb_clock_gen (
        .clk_o (clk)
    );

    fp_adder i_fp_adder (
        .clk_i   (clk),
        .rst_i   (rst),
        .fp_a_i  (fp_a),
        .fp_b_i  (fp_b),
        .valid_i (valid_in),
        .fp_o    (fp_out),
        .valid_o (valid_out)
    );

    //////////////////////////////////////////////////
    // Reference model on plain integers

    function automatic fp_word_t model_add(input fp_word_t a, input fp_word_t b);
        fp_word_t r;
        int       ma;
        int       mb;
        int       m_big;
        int       m_small;
        int       s_big;
        int       s_small;
        int       exp_r;
        int       shift;
        int       value;
        int       mag;
        int       msb;
        bit       sign;
        // Hidden bit at 24, round bit at 0, subnormal as exponent 1
        ma = int'(a.frac) * 2 + ((a.exp != 0) ? (1 << 24) : 0);
        mb = int'(b.frac) * 2 + ((b.exp != 0) ? (1 << 24) : 0);
        if (((a.exp == 0) ? 1 : a.exp) < ((b.exp == 0) ? 1 : b.exp)) begin
            exp_r   = b.exp;
            shift   = b.exp - ((a.exp == 0) ? 1 : a.exp);
            m_big   = mb;
            s_big   = b.sign;
            m_small = ma;
            s_small = a.sign;
        end else begin
            exp_r   = (a.exp == 0) ? 1 : a.exp;
            shift   = exp_r - ((b.exp == 0) ? 1 : b.exp);
            m_big   = ma;
            s_big   = a.sign;
            m_small = mb;
            s_small = b.sign;
        end
        // Align, then half up on the last bit shifted out
        m_small = (shift > SHIFT_LIMIT) ? 0 : (m_small >> shift);
        if (m_small % 2 == 1) begin
            m_small = m_small + 1;
        end
        value = (s_big ? -m_big : m_big) + (s_small ? -m_small : m_small);
        mag   = (value < 0) ? -value : value;
        sign  = (s_big == s_small) ? s_big[0] : (value < 0);
        // Normalize, zero result is always +0
        if (mag == 0) begin
            exp_r = 0;
            sign  = 1'b0;
        end else if (mag >= (1 << 25)) begin
            mag   = mag / 2;
            exp_r = exp_r + 1;
        end else begin
            msb = 0;
            for (int i = 0; i < 25; i++) begin
                if (mag >= (1 << i)) begin
                    msb = i;
                end
            end
            if (exp_r > 24 - msb) begin
                mag   = mag << (24 - msb);
                exp_r = exp_r - (24 - msb);
            end else begin
                // Underflow flush keeps the sign
                mag   = 0;
                exp_r = 0;
            end
        end
        if (mag % 2 == 1) begin
            mag = mag + 1;
            if (mag >= (1 << 25)) begin
                mag   = mag / 2;
                exp_r = exp_r + 1;
            end
        end
        r.sign = sign;
        r.exp  = exp_r[7:0];
        r.frac = mag[23:1];
        return r;
    endfunction

    // Exponent 1 to 200, never reserved or overflowing
    function automatic fp_word_t random_operand();
        fp_word_t w;
        w.sign = 1'($urandom_range(1));
        w.exp  = 8'($urandom_range(200, 1));
        w.frac = 23'($urandom);
        return w;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks and bookkeeping

    task automatic check_word(input string name, input fp_word_t expected,
                              input fp_word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_valid(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s valid: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count > errors_at_start) begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // One pair in, result read PIPE_DEPTH edges later
    task automatic run_pair(input string name, input fp_word_t a, input fp_word_t b,
                            input fp_word_t expected);
        @(negedge clk);
        fp_a     = a;
        fp_b     = b;
        valid_in = 1'b1;
        @(negedge clk);
        valid_in = 1'b0;
        repeat (PIPE_DEPTH - 1) @(negedge clk);
        check_valid(name, 1'b1, valid_out);
        check_word(name, expected, fp_out);
    endtask

    //////////////////////////////////////////////////
    // Directed tests

    task automatic test_reset_idle();
        start_test();
        rst      = 1'b1;
        valid_in = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (20) begin
            @(negedge clk);
            check_valid("reset_idle", 1'b0, valid_out);
        end
        finish_test("reset_idle");
    endtask

    task automatic test_like_signs();
        start_test();
        // 1.0 + 1.0, 1.5 + 2.25 and the negated pairs
        run_pair("like_signs", 32'h3f80_0000, 32'h3f80_0000, 32'h4000_0000);
        run_pair("like_signs", 32'h3fc0_0000, 32'h4010_0000, 32'h4070_0000);
        run_pair("like_signs", 32'hbf80_0000, 32'hbf80_0000, 32'hc000_0000);
        run_pair("like_signs", 32'hbfc0_0000, 32'hc010_0000, 32'hc070_0000);
        finish_test("like_signs");
    endtask

    task automatic test_unlike_signs();
        start_test();
        // Exact cancellation in both orders gives +0
        run_pair("unlike_signs", 32'h4049_0fdb, 32'hc049_0fdb, 32'h0000_0000);
        run_pair("unlike_signs", 32'hc049_0fdb, 32'h4049_0fdb, 32'h0000_0000);
        // 1.0 - 3.0 and -1.0 + 3.0
        run_pair("unlike_signs", 32'h3f80_0000, 32'hc040_0000, 32'hc000_0000);
        run_pair("unlike_signs", 32'hbf80_0000, 32'h4040_0000, 32'h4000_0000);
        finish_test("unlike_signs");
    endtask

    task automatic test_align_round();
        start_test();
        // Gaps of 32 and 25, lesser operand lost entirely
        run_pair("align_round", 32'h3f80_0000, 32'h2f80_0000, 32'h3f80_0000);
        run_pair("align_round", 32'hb300_0000, 32'h3f80_0000, 32'h3f80_0000);
        // Shifted-out bit set
        run_pair("align_round", 32'h3f80_0000, 32'h3f00_0001,
                 model_add(32'h3f80_0000, 32'h3f00_0001));
        run_pair("align_round", 32'h4000_0000, 32'h3e80_0007,
                 model_add(32'h4000_0000, 32'h3e80_0007));
        finish_test("align_round");
    endtask

    task automatic test_zero_subnormal();
        start_test();
        run_pair("zero_subnormal", 32'h0000_0000, 32'h4049_0fdb, 32'h4049_0fdb);
        run_pair("zero_subnormal", 32'h0000_0000, 32'hc120_0000, 32'hc120_0000);
        // Subnormal pairs, one flushed and one reaching the normal range
        run_pair("zero_subnormal", 32'h0000_0003, 32'h0040_0001,
                 model_add(32'h0000_0003, 32'h0040_0001));
        run_pair("zero_subnormal", 32'h0040_0000, 32'h0040_0000,
                 model_add(32'h0040_0000, 32'h0040_0000));
        // Close normals, difference below the normal range
        run_pair("zero_subnormal", 32'h0080_0001, 32'h8080_0000,
                 model_add(32'h0080_0001, 32'h8080_0000));
        run_pair("zero_subnormal", 32'h8080_0001, 32'h0080_0000,
                 model_add(32'h8080_0001, 32'h0080_0000));
        finish_test("zero_subnormal");
    endtask

    task automatic test_stream();
        fp_word_t a;
        fp_word_t b;
        bit       sent_q[$];
        fp_word_t expect_q[$];
        int       issued;
        int       cycle;
        start_test();
        issued = 0;
        cycle  = 0;
        while (issued < STREAM_LEN || cycle < sent_q.size() + PIPE_DEPTH) begin
            @(negedge clk);
            // Whatever was driven PIPE_DEPTH cycles back shows now
            if (cycle >= PIPE_DEPTH) begin
                check_valid("stream", sent_q[cycle - PIPE_DEPTH], valid_out);
                if (sent_q[cycle - PIPE_DEPTH]) begin
                    check_word("stream", expect_q[cycle - PIPE_DEPTH], fp_out);
                end
            end
            if (issued < STREAM_LEN) begin
                a    = random_operand();
                b    = random_operand();
                fp_a = a;
                fp_b = b;
                // About one cycle in eight idle
                valid_in = ($urandom_range(7) != 0);
                sent_q.push_back(valid_in);
                expect_q.push_back(model_add(a, b));
                if (valid_in) begin
                    issued++;
                end
            end else begin
                valid_in = 1'b0;
            end
            cycle++;
        end
        finish_test("stream");
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog

    initial begin
        void'($urandom(32'hcf8e_41d3));
        rst      = 1'b1;
        fp_a     = '0;
        fp_b     = '0;
        valid_in = 1'b0;
        test_reset_idle();
        test_like_signs();
        test_unlike_signs();
        test_align_round();
        test_zero_subnormal();
        test_stream();
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, check_count, error_count,
                 i_fp_adder.i_fp_adder_properties.fail_count);
        if (error_count == 0 && i_fp_adder.i_fp_adder_properties.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout after %0d time units, tests did not complete", WATCHDOG_TIME);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/fpa_pkg.sv
source/fpa_align.sv
source/fpa_signed_add.sv
source/fpa_normalize.sv
source/fp_adder.sv
tb/tb_clock_gen.sv
tb/fp_adder_properties.sv
tb/fp_adder_tb.sv

//--- Bender.yml
package:
  name: fp_adder

sources:
  # Design, in compile order
  - files:
      - source/fpa_pkg.sv
      - source/fpa_align.sv
      - source/fpa_signed_add.sv
      - source/fpa_normalize.sv
      - source/fp_adder.sv

  # Testbench, top module fp_adder_tb
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/fp_adder_properties.sv
      - tb/fp_adder_tb.sv
